//--- Makefile
# Verilator simulation of the single-cycle RV32I core

run: obj_dir/Vtb_cpu
	./obj_dir/Vtb_cpu

obj_dir/Vtb_cpu: cpu.f $(shell cat cpu.f)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f cpu.f

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- alu.sv
// Arithmetic logic unit
`timescale 1ns/10ps
`default_nettype none

module alu import cpu_pkg::*; (
  input  ctrl_t           ctrl,
  input  logic [2:0]      funct3,    // branch kind
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  input  logic [xlen-1:0] imm,
  output logic [xlen-1:0] result,
  output logic            bcond
);

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [4:0]      shamt;

  assign op_a  = ctrl.alu_src_pc ? pc : rs1_data;  // auipc uses pc
  assign op_b  = ctrl.alu_src_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      alu_add:    result = op_a + op_b;
      alu_sub:    result = op_a - op_b;
      alu_sll:    result = op_a << shamt;
      alu_slt:    result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu:   result = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_xor:    result = op_a ^ op_b;
      alu_srl:    result = op_a >> shamt;
      alu_sra:    result = $unsigned($signed(op_a) >>> shamt);  // keep sign
      alu_or:     result = op_a | op_b;
      alu_and:    result = op_a & op_b;
      alu_pass_b: result = op_b;
      default:    result = '0;
    endcase
  end

  // compare the register pair directly, independent of operand muxing
  always_comb begin
    case (funct3)
      f3_beq:  bcond = (rs1_data == rs2_data);
      f3_bne:  bcond = (rs1_data != rs2_data);
      f3_blt:  bcond = ($signed(rs1_data) < $signed(rs2_data));
      f3_bge:  bcond = ($signed(rs1_data) >= $signed(rs2_data));
      f3_bltu: bcond = (rs1_data < rs2_data);
      f3_bgeu: bcond = (rs1_data >= rs2_data);
      default: bcond = 1'b0;  // 010/011 not valid branches
    endcase
  end

endmodule

`default_nettype wire

//--- cpu.f
cpu_pkg.sv
fetch_unit.sv
decoder.sv
register_file.sv
alu.sv
mem_stage.sv
cpu.sv
tb_cpu.sv

//--- cpu.sv
// Single-cycle RV32I core
`timescale 1ns/10ps
`default_nettype none

module cpu import cpu_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  output logic    halted,   // sticky after exit ecall
  output commit_t commit    // retiring instruction
);

  inst_u           instr;
  ctrl_t           ctrl;
  logic [xlen-1:0] pc;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [4:0]      rd;
  logic [2:0]      funct3;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] a7_data;
  logic [xlen-1:0] alu_result;
  logic            bcond;
  logic [xlen-1:0] wb_data;
  logic            rf_we;

  assign rf_we = ctrl.reg_write & ~halted;  // freeze registers once halted

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      halted <= 1'b0;
    end else if (ctrl.is_ecall && (a7_data == exit_code)) begin
      halted <= 1'b1;  // other ecalls fall through as no-ops
    end
  end

  fetch_unit u_fetch (
    .clk(clk), .rst_n(rst_n), .halted(halted), .ctrl(ctrl), .bcond(bcond),
    .imm(imm), .alu_result(alu_result), .pc(pc), .instr(instr)
  );

  decoder u_dec (
    .instr(instr), .ctrl(ctrl), .rs1(rs1), .rs2(rs2), .rd(rd),
    .imm(imm), .funct3(funct3)
  );

  register_file u_rf (
    .clk(clk), .rst_n(rst_n), .we(rf_we), .rs1(rs1), .rs2(rs2), .rd(rd),
    .rd_data(wb_data), .rs1_data(rs1_data), .rs2_data(rs2_data), .a7_data(a7_data)
  );

  alu u_alu (
    .ctrl(ctrl), .funct3(funct3), .pc(pc), .rs1_data(rs1_data),
    .rs2_data(rs2_data), .imm(imm), .result(alu_result), .bcond(bcond)
  );

  mem_stage u_mem (
    .clk(clk), .rst_n(rst_n), .halted(halted), .ctrl(ctrl), .pc(pc),
    .alu_result(alu_result), .rs2_data(rs2_data), .instr(instr), .rd(rd),
    .wb_data(wb_data), .commit(commit)
  );

endmodule

`default_nettype wire

//--- cpu_pkg.sv
// RV32I core shared definitions
`default_nettype none

package cpu_pkg;

  localparam int xlen       = 32;
  localparam int imem_words = 256;
  localparam int dmem_words = 256;
  localparam int imem_aw    = $clog2(imem_words);  // word index bits
  localparam int dmem_aw    = $clog2(dmem_words);

  localparam string program_file = "program.hex";
  localparam logic [xlen-1:0] reset_pc = '0;

  // ecall halts when a7 (x17) holds this
  localparam logic [4:0]      reg_a7    = 5'd17;
  localparam logic [xlen-1:0] exit_code = 32'd10;

  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam logic [2:0] f3_beq  = 3'b000;  // branch conditions
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  localparam logic [3:0] alu_add    = 4'd0;
  localparam logic [3:0] alu_sub    = 4'd1;
  localparam logic [3:0] alu_sll    = 4'd2;
  localparam logic [3:0] alu_slt    = 4'd3;
  localparam logic [3:0] alu_sltu   = 4'd4;
  localparam logic [3:0] alu_xor    = 4'd5;
  localparam logic [3:0] alu_srl    = 4'd6;
  localparam logic [3:0] alu_sra    = 4'd7;
  localparam logic [3:0] alu_or     = 4'd8;
  localparam logic [3:0] alu_and    = 4'd9;
  localparam logic [3:0] alu_pass_b = 4'd10;  // lui

  typedef union packed {
    struct packed {logic [6:0] funct7; logic [4:0] rs2, rs1; logic [2:0] funct3;
                   logic [4:0] rd; logic [6:0] opcode;} r_fmt;
    struct packed {logic [11:0] imm; logic [4:0] rs1; logic [2:0] funct3;
                   logic [4:0] rd; logic [6:0] opcode;} i_fmt;
    struct packed {logic [6:0] imm_hi; logic [4:0] rs2, rs1; logic [2:0] funct3;
                   logic [4:0] imm_lo; logic [6:0] opcode;} s_fmt;
    struct packed {logic imm_12; logic [5:0] imm_10_5; logic [4:0] rs2, rs1;
                   logic [2:0] funct3; logic [3:0] imm_4_1; logic imm_11;
                   logic [6:0] opcode;} b_fmt;
    struct packed {logic [19:0] imm; logic [4:0] rd; logic [6:0] opcode;} u_fmt;
    struct packed {logic imm_20; logic [9:0] imm_10_1; logic imm_11;
                   logic [7:0] imm_19_12; logic [4:0] rd; logic [6:0] opcode;} j_fmt;
    logic [31:0] raw;
  } inst_u;

  typedef struct packed {
    logic [3:0] alu_op;
    logic       alu_src_imm;  // b = imm
    logic       alu_src_pc;   // a = pc, auipc
    logic       branch;
    logic       is_jal;
    logic       is_jalr;
    logic       mem_read;
    logic       mem_write;
    logic       reg_write;
    logic       wb_link;      // rd gets pc+4
    logic       is_ecall;
  } ctrl_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [31:0]     instr;
    logic            reg_write;
    logic [4:0]      rd;
    logic [xlen-1:0] rd_data;
    logic            mem_write;
    logic [xlen-1:0] mem_addr;
    logic [xlen-1:0] mem_data;
  } commit_t;

endpackage

`default_nettype wire

//--- decoder.sv
// Instruction decoder
`timescale 1ns/10ps
`default_nettype none

module decoder import cpu_pkg::*; (
  input  inst_u           instr,
  output ctrl_t           ctrl,
  output logic [4:0]      rs1,
  output logic [4:0]      rs2,
  output logic [4:0]      rd,
  output logic [xlen-1:0] imm,
  output logic [2:0]      funct3
);

  logic [6:0]      opcode;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  logic            alt;     // funct7 bit 5, sub / sra select

  // funct3 to alu op for op and op-imm groups
  function automatic logic [3:0] arith_op(input logic [2:0] f3, input logic alt_sel);
    case (f3)
      3'b000:  arith_op = alt_sel ? alu_sub : alu_add;
      3'b001:  arith_op = alu_sll;
      3'b010:  arith_op = alu_slt;
      3'b011:  arith_op = alu_sltu;
      3'b100:  arith_op = alu_xor;
      3'b101:  arith_op = alt_sel ? alu_sra : alu_srl;
      3'b110:  arith_op = alu_or;
      default: arith_op = alu_and;
    endcase
  endfunction

  assign opcode = instr.r_fmt.opcode;
  assign rs1    = instr.r_fmt.rs1;  // field positions shared across formats
  assign rs2    = instr.r_fmt.rs2;
  assign rd     = instr.r_fmt.rd;
  assign funct3 = instr.r_fmt.funct3;
  assign alt    = instr.r_fmt.funct7[5];

  // sign-extended immediates, one per format view
  assign imm_i = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
  assign imm_s = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
  assign imm_b = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                  instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {instr.u_fmt.imm, 12'b0};
  assign imm_j = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
                  instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};

  always_comb begin
    ctrl = '0;  // unknown opcode is a no-op
    imm  = '0;
    case (opcode)
      op_lui: begin
        ctrl.alu_op      = alu_pass_b;
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        imm              = imm_u;
      end
      op_auipc: begin
        ctrl.alu_op      = alu_add;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_src_pc  = 1'b1;  // pc + upper imm
        ctrl.reg_write   = 1'b1;
        imm              = imm_u;
      end
      op_jal: begin
        ctrl.is_jal    = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.wb_link   = 1'b1;
        imm            = imm_j;
      end
      op_jalr: begin
        ctrl.alu_op      = alu_add;  // target = rs1 + imm
        ctrl.alu_src_imm = 1'b1;
        ctrl.is_jalr     = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.wb_link     = 1'b1;
        imm              = imm_i;
      end
      op_branch: begin
        ctrl.alu_op = alu_sub;  // result unused, bcond decides
        ctrl.branch = 1'b1;
        imm         = imm_b;
      end
      op_load: begin
        ctrl.alu_op      = alu_add;
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.reg_write   = 1'b1;
        imm              = imm_i;
      end
      op_store: begin
        ctrl.alu_op      = alu_add;
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;
        imm              = imm_s;
      end
      op_imm: begin
        ctrl.alu_op      = arith_op(funct3, alt & (funct3 == 3'b101));  // srai only
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        imm              = imm_i;
      end
      op_reg: begin
        ctrl.alu_op    = arith_op(funct3, alt);
        ctrl.reg_write = 1'b1;
      end
      op_system: begin
        ctrl.is_ecall = (funct3 == 3'b000) && (instr.i_fmt.imm == 12'd0);  // ecall only
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- fetch_unit.sv
// Fetch unit
`timescale 1ns/10ps
`default_nettype none

module fetch_unit import cpu_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            halted,      // freeze pc after exit ecall
  input  ctrl_t           ctrl,
  input  logic            bcond,       // branch condition from alu
  input  logic [xlen-1:0] imm,
  input  logic [xlen-1:0] alu_result,  // jalr target before bit-0 clear
  output logic [xlen-1:0] pc,
  output inst_u           instr
);

  logic [xlen-1:0] rom [imem_words];  // instruction rom
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] pc_target;         // pc-relative target, jal and branches
  logic [xlen-1:0] next_pc;
  logic            take_rel;

  initial begin
    $readmemh(program_file, rom);  // program image
  end

  assign instr = rom[pc[imem_aw+1:2]];  // word index, low bits dropped

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + imm;
  assign take_rel  = ctrl.is_jal | (ctrl.branch & bcond);

  always_comb begin
    if (ctrl.is_jalr) begin
      next_pc = {alu_result[xlen-1:1], 1'b0};  // rs1+imm, lsb cleared
    end else if (take_rel) begin
      next_pc = pc_target;
    end else begin
      next_pc = pc_plus4;  // sequential
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else if (!halted) begin
      pc <= next_pc;  // one instruction per edge
    end
  end

endmodule

`default_nettype wire

//--- mem_stage.sv
// Data memory and writeback
`timescale 1ns/10ps
`default_nettype none

module mem_stage import cpu_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            halted,
  input  ctrl_t           ctrl,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] alu_result,  // load/store address
  input  logic [xlen-1:0] rs2_data,    // store data
  input  inst_u           instr,
  input  logic [4:0]      rd,
  output logic [xlen-1:0] wb_data,
  output commit_t         commit
);

  logic [xlen-1:0]    dmem [dmem_words];
  logic [dmem_aw-1:0] widx;      // word index, byte offset ignored
  logic [xlen-1:0]    load_data;

  assign widx      = alu_result[dmem_aw+1:2];
  assign load_data = dmem[widx];  // async read

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < dmem_words; i++) begin
        dmem[i] <= '0;
      end
    end else if (ctrl.mem_write && !halted) begin
      dmem[widx] <= rs2_data;
    end
  end

  always_comb begin
    if (ctrl.wb_link) begin
      wb_data = pc + 32'd4;  // jal / jalr link
    end else if (ctrl.mem_read) begin
      wb_data = load_data;
    end else begin
      wb_data = alu_result;
    end
  end

  always_comb begin
    commit.valid     = rst_n && !halted;
    commit.pc        = pc;
    commit.instr     = instr.raw;
    commit.reg_write = ctrl.reg_write;
    commit.rd        = rd;
    commit.rd_data   = (rd == 5'd0) ? '0 : wb_data;  // x0 reads zero
    commit.mem_write = ctrl.mem_write;
    commit.mem_addr  = alu_result;
    commit.mem_data  = rs2_data;
  end

endmodule

`default_nettype wire

//--- program.hex
// one 32-bit instruction word per line, in address order from 0
// trailing comment gives the byte address and the assembly
00500093  // 00 addi x1, x0, 5
ffd00113  // 04 addi x2, x0, -3
002081b3  // 08 add  x3, x1, x2
40208233  // 0c sub  x4, x1, x2
001092b3  // 10 sll  x5, x1, x1
00112333  // 14 slt  x6, x2, x1
001133b3  // 18 sltu x7, x2, x1
0020c433  // 1c xor  x8, x1, x2
001154b3  // 20 srl  x9, x2, x1
40115533  // 24 sra  x10, x2, x1
0020e5b3  // 28 or   x11, x1, x2
0020f633  // 2c and  x12, x1, x2
00309693  // 30 slli x13, x1, 3
00415713  // 34 srli x14, x2, 4
40115793  // 38 srai x15, x2, 1
00012813  // 3c slti x16, x2, 0
0060b913  // 40 sltiu x18, x1, 6
fff0c993  // 44 xori x19, x1, -1
0700ea13  // 48 ori  x20, x1, 0x70
0ff17a93  // 4c andi x21, x2, 0xff
12345b37  // 50 lui  x22, 0x12345
00001b97  // 54 auipc x23, 1
00708013  // 58 addi x0, x1, 7
01602423  // 5c sw   x22, 8(x0)
0040a3a3  // 60 sw   x4, 7(x1)
00802c03  // 64 lw   x24, 8(x0)
00c02c83  // 68 lw   x25, 12(x0)
00208463  // 6c beq  x1, x2, +8   not taken
00108463  // 70 beq  x1, x1, +8   taken
06300d13  // 74 addi x26, x0, 99  skipped
00109463  // 78 bne  x1, x1, +8   not taken
00209463  // 7c bne  x1, x2, +8   taken
06300d13  // 80 addi x26, x0, 99  skipped
0020c463  // 84 blt  x1, x2, +8   not taken
00114463  // 88 blt  x2, x1, +8   taken
06300d13  // 8c addi x26, x0, 99  skipped
00115463  // 90 bge  x2, x1, +8   not taken
0020d463  // 94 bge  x1, x2, +8   taken
06300d13  // 98 addi x26, x0, 99  skipped
00116463  // 9c bltu x2, x1, +8   not taken
0020e463  // a0 bltu x1, x2, +8   taken
06300d13  // a4 addi x26, x0, 99  skipped
0020f463  // a8 bgeu x1, x2, +8   not taken
00117463  // ac bgeu x2, x1, +8   taken
06300d13  // b0 addi x26, x0, 99  skipped
00300d93  // b4 addi x27, x0, 3
002e0e13  // b8 loop: addi x28, x28, 2
fffd8d93  // bc addi x27, x27, -1
fe0d9ce3  // c0 bne  x27, x0, loop
010000ef  // c4 jal  x1, func
01c02823  // c8 sw   x28, 16(x0)
01002e83  // cc lw   x29, 16(x0)
00c0006f  // d0 jal  x0, +12
01c08f33  // d4 func: add x30, x1, x28
00108fe7  // d8 jalr x31, 1(x1)
00000073  // dc ecall with x17 = 0
00a00893  // e0 addi x17, x0, 10
00000073  // e4 ecall, exit
06300d13  // e8 addi x26, x0, 99  never reached

//--- register_file.sv
// Integer register file
`timescale 1ns/10ps
`default_nettype none

module register_file import cpu_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            we,        // already gated by halted
  input  logic [4:0]      rs1,
  input  logic [4:0]      rs2,
  input  logic [4:0]      rd,
  input  logic [xlen-1:0] rd_data,
  output logic [xlen-1:0] rs1_data,
  output logic [xlen-1:0] rs2_data,
  output logic [xlen-1:0] a7_data    // x17 for halt check
);

  logic [xlen-1:0] regs [32];  // x0 never written, stays zero

  assign rs1_data = regs[rs1];  // async read
  assign rs2_data = regs[rs2];
  assign a7_data  = regs[reg_a7];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != 5'd0)) begin
      regs[rd] <= rd_data;  // drop writes to x0
    end
  end

endmodule

`default_nettype wire

//--- tb_cpu.sv
// RV32I core testbench
`timescale 1ns/10ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

  localparam int max_cycles  = 1000;  // about 60 retired + 8 reset + 20 idle with wide margin
  localparam int quiet_limit = 20;    // idle cycles watched after halt

  logic    clk   = 1'b0;
  logic    rst_n = 1'b0;
  logic    halted;
  commit_t commit;

  logic [xlen-1:0] m_regs [32];  // reference architectural state
  logic [xlen-1:0] m_dmem [dmem_words];
  logic [xlen-1:0] m_prog [imem_words];
  logic [xlen-1:0] m_pc;
  logic            m_halted;    // model executed the exit ecall

  commit_t expected;
  int      cycles;
  int      retired;
  int      quiet;

  cpu DUT (.clk(clk), .rst_n(rst_n), .halted(halted), .commit(commit));

  always #5 clk = ~clk;  // 10 ns period

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_field(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    assert (act_val === exp_val) else begin
      fail_run($sformatf("ERROR at %0t: %s expected %h got %h",
                         $time, name, exp_val, act_val));
    end
  endtask

  // op and op-imm result from funct3 with alt selecting sub or sra
  function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    arith = alt ? a - b : a + b;
      3'd1:    arith = a << b[4:0];
      3'd2:    arith = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    arith = (a < b) ? 32'd1 : 32'd0;
      3'd4:    arith = a ^ b;
      3'd5:    arith = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    arith = a | b;
      default: arith = a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'd0:    branch_taken = (a == b);
      3'd1:    branch_taken = (a != b);
      3'd4:    branch_taken = ($signed(a) < $signed(b));
      3'd5:    branch_taken = ($signed(a) >= $signed(b));
      3'd6:    branch_taken = (a < b);
      3'd7:    branch_taken = (a >= b);
      default: branch_taken = 1'b0;
    endcase
  endfunction

  // executes one instruction on the model state and returns its commit
  function automatic commit_t step_model();
    commit_t     c;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] value;
    logic [31:0] addr;
    logic [31:0] next_pc;
    logic [4:0]  rd;
    logic        wr;
    ins   = m_prog[(m_pc >> 2) % imem_words];
    rd    = ins[11:7];
    a     = m_regs[ins[19:15]];
    b     = m_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u = {ins[31:12], 12'b0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    c         = '0;
    c.valid   = 1'b1;
    c.pc      = m_pc;
    c.instr   = ins;
    c.rd      = rd;
    next_pc   = m_pc + 32'd4;
    value     = '0;
    addr      = '0;
    wr        = 1'b0;
    case (ins[6:0])
      op_lui: begin
        wr    = 1'b1;
        value = imm_u;
      end
      op_auipc: begin
        wr    = 1'b1;
        value = m_pc + imm_u;
      end
      op_jal: begin
        wr      = 1'b1;
        value   = m_pc + 32'd4;  // link
        next_pc = m_pc + imm_j;
      end
      op_jalr: begin
        wr      = 1'b1;
        value   = m_pc + 32'd4;
        next_pc = (a + imm_i) & ~32'd1;
      end
      op_branch: begin
        if (branch_taken(ins[14:12], a, b)) begin
          next_pc = m_pc + imm_b;
        end
      end
      op_load: begin
        wr    = 1'b1;
        addr  = a + imm_i;
        value = m_dmem[(addr >> 2) % dmem_words];  // word access only
      end
      op_store: begin
        addr        = a + imm_s;
        c.mem_write = 1'b1;
        c.mem_addr  = addr;
        c.mem_data  = b;
        m_dmem[(addr >> 2) % dmem_words] = b;
      end
      op_imm: begin
        wr    = 1'b1;
        value = arith(ins[14:12], ins[30] && (ins[14:12] == 3'd5), a, imm_i);
      end
      op_reg: begin
        wr    = 1'b1;
        value = arith(ins[14:12], ins[30], a, b);
      end
      op_system: begin
        if (ins[31:7] == 25'd0 && m_regs[17] == 32'd10) begin
          m_halted = 1'b1;  // exit ecall
        end
      end
      default: begin
      end
    endcase
    c.reg_write = wr;
    c.rd_data   = (rd == 5'd0) ? 32'd0 : value;
    if (wr && rd != 5'd0) begin
      m_regs[rd] = value;
    end
    m_pc = next_pc;
    return c;
  endfunction

  initial begin
    m_pc     = 32'd0;
    m_halted = 1'b0;
    cycles   = 0;
    retired  = 0;
    quiet    = 0;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    for (int i = 0; i < dmem_words; i++) begin
      m_dmem[i] = '0;  // matches dmem clear under reset
    end
    $readmemh(program_file, m_prog);
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;  // release just after the edge
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    assert (cycles < max_cycles) else fail_run("timeout, the core never reached its exit");
  end

  // sample mid-cycle once outputs have settled
  always @(negedge clk) begin
    if (!rst_n) begin
      assert (!commit.valid && !halted) else fail_run("commit valid or halted set in reset");
    end else if (halted) begin
      assert (m_halted) else fail_run("DUT halted before the model reached its exit ecall");
      assert (!commit.valid) else fail_run("commit valid after the core halted");
      quiet = quiet + 1;
      if (quiet == quiet_limit) begin
        $display("retired %0d instructions", retired);
        $display("sim passed");
        $finish;
      end
    end else begin
      assert (!m_halted) else fail_run("DUT halted late, the model already left on ecall");
      assert (commit.valid) else fail_run("commit valid low while the core runs");
      if (retired == 0) begin
        check_field("commit.pc first", 32'd0, commit.pc);  // first commit at address 0
      end
      expected = step_model();
      retired  = retired + 1;
      check_field("commit.pc", expected.pc, commit.pc);
      check_field("commit.instr", expected.instr, commit.instr);
      check_field("commit.reg_write", 32'(expected.reg_write), 32'(commit.reg_write));
      check_field("commit.rd", 32'(expected.rd), 32'(commit.rd));
      check_field("commit.mem_write", 32'(expected.mem_write), 32'(commit.mem_write));
      if (expected.reg_write) begin
        check_field("commit.rd_data", expected.rd_data, commit.rd_data);
      end
      if (expected.mem_write) begin
        check_field("commit.mem_addr", expected.mem_addr, commit.mem_addr);
        check_field("commit.mem_data", expected.mem_data, commit.mem_data);
      end
    end
  end

endmodule

`default_nettype wire
